// ==== filelist.f ====
verilog/bus_pkg.sv
verilog/clint_timer.sv
verilog/sram_slave.sv
verilog/bus_arbiter.sv
verilog/mem_subsys_top.sv
verif/mem_subsys_tb.sv

// ==== Makefile ====
TOP = mem_subsys_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb;

  localparam int SRAM_WORDS   = 1024;
  localparam int RESP_LATENCY = 3;
  localparam int IDX_W        = $clog2(SRAM_WORDS) + 1;
  localparam int N_RAND       = 8;
  // random pairs, two lanes of merge tests, fetch plus load, three timer loads
  localparam int N_TRANS      = 2 * N_RAND + 2 * 17 + 2 + 3;
  localparam int LIMIT        = N_TRANS * (RESP_LATENCY + 6) * 2;
  localparam logic [31:0] ADDR_MASK = 32'(SRAM_WORDS * 8 - 4);

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 ifu_arvalid_i;
  logic [31:0]          ifu_araddr_i;
  logic                 ifu_rvalid_o;
  logic [31:0]          ifu_rdata_o;
  logic                 lsu_arvalid_i;
  logic [31:0]          lsu_araddr_i;
  bus_pkg::size_t       lsu_rsize_i;
  logic                 lsu_rvalid_o;
  logic [31:0]          lsu_rdata_o;
  logic                 lsu_awvalid_i;
  logic [31:0]          lsu_awaddr_i;
  logic [31:0]          lsu_wdata_i;
  bus_pkg::size_t       lsu_wsize_i;
  logic                 lsu_wready_o;

  logic [31:0] shadow [0:2**IDX_W-1];
  logic [31:0] ifu_exp_q[$];
  logic [31:0] lsu_exp_q[$];
  logic [31:0] rng;
  logic [31:0] lane_addr [0:1];
  logic        tmr_pending;
  int          cycles;
  int          checks;
  int          errors;

  mem_subsys_top
  #(
    .SRAM_WORDS   (SRAM_WORDS),
    .RESP_LATENCY (RESP_LATENCY)
  )
  uut
  (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rsize_i   (lsu_rsize_i),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wsize_i   (lsu_wsize_i),
    .lsu_wready_o  (lsu_wready_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected word after a store
  // a byte changes one byte, a half two and a word all four
  function automatic logic [31:0] merge_store(input logic [31:0] old_word,
                                              input logic [1:0] off,
                                              input logic [31:0] data,
                                              input bus_pkg::size_t size);
    logic [31:0] w;
    int          o;
    int          n;
    w = old_word;
    o = int'(off);
    case (size)
      bus_pkg::SIZE_BYTE: n = 1;
      bus_pkg::SIZE_HALF: n = 2;
      default:            n = 4;
    endcase
    for (int k = 0; k < 4; k++)
    begin
      if (k >= o && k < o + n)
      begin
        w[8*k +: 8] = data[8*(k-o) +: 8];
      end
    end
    return w;
  endfunction

  task automatic store(input logic [31:0] addr, input logic [31:0] data,
                       input bus_pkg::size_t size);
    @(posedge clk);
    lsu_awvalid_i <= 1'b1;
    lsu_awaddr_i  <= addr;
    lsu_wdata_i   <= data;
    lsu_wsize_i   <= size;
    do @(negedge clk); while (!lsu_wready_o);
    @(posedge clk);
    lsu_awvalid_i <= 1'b0;
    shadow[addr[IDX_W+1:2]] = merge_store(shadow[addr[IDX_W+1:2]], addr[1:0], data, size);
  endtask

  task automatic fetch(input logic [31:0] addr);
    ifu_exp_q.push_back(shadow[addr[IDX_W+1:2]]);
    @(posedge clk);
    ifu_arvalid_i <= 1'b1;
    ifu_araddr_i  <= addr;
    do @(negedge clk); while (!ifu_rvalid_o);
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
  endtask

  task automatic load(input logic [31:0] addr, input bus_pkg::size_t size);
    lsu_exp_q.push_back(shadow[addr[IDX_W+1:2]]);
    @(posedge clk);
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= addr;
    lsu_rsize_i   <= size;
    do @(negedge clk); while (!lsu_rvalid_o);
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
  endtask

  // load raised together with a fetch has to finish first
  task automatic fetch_and_load(input logic [31:0] ia, input logic [31:0] la);
    logic ifu_done;
    logic lsu_done;
    ifu_done = 1'b0;
    lsu_done = 1'b0;
    ifu_exp_q.push_back(shadow[ia[IDX_W+1:2]]);
    lsu_exp_q.push_back(shadow[la[IDX_W+1:2]]);
    @(posedge clk);
    ifu_arvalid_i <= 1'b1;
    ifu_araddr_i  <= ia;
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= la;
    lsu_rsize_i   <= bus_pkg::SIZE_WORD;
    while (!(ifu_done && lsu_done))
    begin
      @(negedge clk);
      if (lsu_rvalid_o)
      begin
        lsu_done = 1'b1;
      end
      if (ifu_rvalid_o)
      begin
        assert (lsu_done)
        else
        begin
          $display("fetch completed before the load raised in the same cycle");
          errors++;
        end
        ifu_done = 1'b1;
      end
      @(posedge clk);
      if (lsu_done)
      begin
        lsu_arvalid_i <= 1'b0;
      end
      if (ifu_done)
      begin
        ifu_arvalid_i <= 1'b0;
      end
    end
  endtask

  // timer loads complete 2 cycles after the idle arbiter sees them
  task automatic timer_load(input logic [31:0] addr, output logic [31:0] value,
                            output int at_cycle);
    int n;
    n = 0;
    tmr_pending = 1'b1;
    @(posedge clk);
    lsu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= addr;
    lsu_rsize_i   <= bus_pkg::SIZE_WORD;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!lsu_rvalid_o);
    value    = lsu_rdata_o;
    at_cycle = cycles;
    checks++;
    assert (n == 3)
    else
    begin
      $display("timer load completed %0d cycles after the request instead of 2", n - 1);
      errors++;
    end
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
    tmr_pending = 1'b0;
  endtask

  // compares every read completion against the shadow memory
  always @(negedge clk)
  begin
    if (ifu_rvalid_o)
    begin
      checks++;
      assert (ifu_exp_q.size() != 0)
      else
      begin
        $display("fetch completed with no fetch outstanding");
        errors++;
      end
      if (ifu_exp_q.size() != 0)
      begin
        assert (ifu_rdata_o == ifu_exp_q[0])
        else
        begin
          $display("Mismatch ifu_rdata_o: got %h, expected %h", ifu_rdata_o, ifu_exp_q[0]);
          errors++;
        end
        void'(ifu_exp_q.pop_front());
      end
    end
    if (lsu_rvalid_o && !tmr_pending)
    begin
      checks++;
      assert (lsu_exp_q.size() != 0)
      else
      begin
        $display("load completed with no load outstanding");
        errors++;
      end
      if (lsu_exp_q.size() != 0)
      begin
        assert (lsu_rdata_o == lsu_exp_q[0])
        else
        begin
          $display("Mismatch lsu_rdata_o: got %h, expected %h", lsu_rdata_o, lsu_exp_q[0]);
          errors++;
        end
        void'(lsu_exp_q.pop_front());
      end
    end
  end

  initial
  begin
    while (cycles < LIMIT)
    begin
      @(posedge clk);
    end
    $display("timeout: a transaction never completed within %0d cycles", LIMIT);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("Something failed");
    $finish;
  end

  initial
  begin
    logic [31:0] addr;
    logic [31:0] base;
    logic [31:0] t_hi;
    logic [31:0] t1;
    logic [31:0] t2;
    int          c1;
    int          c2;
    rst           = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = 32'd0;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i  = 32'd0;
    lsu_rsize_i   = bus_pkg::SIZE_WORD;
    lsu_awvalid_i = 1'b0;
    lsu_awaddr_i  = 32'd0;
    lsu_wdata_i   = 32'd0;
    lsu_wsize_i   = bus_pkg::SIZE_WORD;
    tmr_pending   = 1'b0;
    rng           = 32'd45360;
    cycles        = 0;
    checks        = 0;
    errors        = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // quiet outputs with nothing requested
    repeat (5)
    begin
      @(negedge clk);
      checks++;
      assert (!ifu_rvalid_o && !lsu_rvalid_o && !lsu_wready_o)
      else
      begin
        $display("completion output high with no request pending");
        errors++;
      end
    end

    // high timer word is still zero this early
    timer_load(bus_pkg::MTIME_ADDR_HI, t_hi, c1);
    assert (t_hi == 32'd0)
    else
    begin
      $display("Mismatch lsu_rdata_o: got %h, expected %h", t_hi, 32'd0);
      errors++;
    end

    for (int i = 0; i < N_RAND; i++)
    begin
      rng  = xorshift32(rng);
      addr = rng & ADDR_MASK;
      rng  = xorshift32(rng);
      store(addr, rng, bus_pkg::SIZE_WORD);
      fetch(addr);
    end

    // sub-word merges in the low and the high lane
    for (int lane = 0; lane < 2; lane++)
    begin
      rng  = xorshift32(rng);
      base = (rng & ADDR_MASK & ~32'h4) | (lane != 0 ? 32'h4 : 32'h0);
      lane_addr[lane] = base;
      rng  = xorshift32(rng);
      store(base, rng, bus_pkg::SIZE_WORD);
      for (int off = 0; off < 4; off++)
      begin
        rng = xorshift32(rng);
        store(base | 32'(off), rng, bus_pkg::SIZE_BYTE);
        load(base | 32'(off), bus_pkg::SIZE_BYTE);
        rng = xorshift32(rng);
        store(base | 32'(off), rng, bus_pkg::SIZE_HALF);
        load(base | 32'(off), bus_pkg::SIZE_HALF);
      end
    end

    fetch_and_load(lane_addr[0], lane_addr[1]);

    timer_load(bus_pkg::MTIME_ADDR, t1, c1);
    repeat (10) @(posedge clk);
    timer_load(bus_pkg::MTIME_ADDR, t2, c2);
    assert (int'(t2 - t1) >= c2 - c1)
    else
    begin
      $display("Mismatch lsu_rdata_o: timer moved by %h, expected at least %h",
               t2 - t1, c2 - c1);
      errors++;
    end

    // no request is served a second time once all are done
    repeat (4)
    begin
      @(negedge clk);
      checks++;
      assert (!ifu_rvalid_o && !lsu_rvalid_o && !lsu_wready_o)
      else
      begin
        $display("completion output high after the last request was served");
        errors++;
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top
#(
  parameter int SRAM_WORDS   = 1024,
  parameter int RESP_LATENCY = 3
)
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  output logic                       ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  input  logic                       lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  bus_pkg::size_t             lsu_rsize_i,
  output logic                       lsu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  input  logic                       lsu_awvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0] lsu_wdata_i,
  input  bus_pkg::size_t             lsu_wsize_i,
  output logic                       lsu_wready_o
);

  // arbiter to sram channels
  logic                       ar_valid;
  logic                       ar_ready;
  logic [bus_pkg::ADDR_W-1:0] ar_addr;
  bus_pkg::size_t             ar_size;
  logic                       r_valid;
  logic [bus_pkg::BUS_W-1:0]  r_data;
  logic                       aw_valid;
  logic                       aw_ready;
  logic [bus_pkg::ADDR_W-1:0] aw_addr;
  bus_pkg::size_t             aw_size;
  logic                       w_valid;
  logic                       w_ready;
  logic [bus_pkg::BUS_W-1:0]  w_data;
  logic [bus_pkg::STRB_W-1:0] w_strb;
  logic                       b_valid;

  // arbiter to timer
  logic                       tmr_rd;
  logic                       tmr_hi;
  logic                       tmr_rvalid;
  logic [bus_pkg::DATA_W-1:0] tmr_rdata;

  bus_arbiter u_arbiter
  (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rsize_i   (lsu_rsize_i),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wsize_i   (lsu_wsize_i),
    .lsu_wready_o  (lsu_wready_o),
    .ar_valid_o    (ar_valid),
    .ar_addr_o     (ar_addr),
    .ar_size_o     (ar_size),
    .ar_ready_i    (ar_ready),
    .r_valid_i     (r_valid),
    .r_data_i      (r_data),
    .aw_valid_o    (aw_valid),
    .aw_addr_o     (aw_addr),
    .aw_size_o     (aw_size),
    .aw_ready_i    (aw_ready),
    .w_valid_o     (w_valid),
    .w_data_o      (w_data),
    .w_strb_o      (w_strb),
    .w_ready_i     (w_ready),
    .b_valid_i     (b_valid),
    .tmr_rd_o      (tmr_rd),
    .tmr_hi_o      (tmr_hi),
    .tmr_rvalid_i  (tmr_rvalid),
    .tmr_rdata_i   (tmr_rdata)
  );

  clint_timer u_timer
  (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (tmr_rd),
    .hi_i     (tmr_hi),
    .rvalid_o (tmr_rvalid),
    .rdata_o  (tmr_rdata)
  );

  sram_slave
  #(
    .SRAM_WORDS   (SRAM_WORDS),
    .RESP_LATENCY (RESP_LATENCY)
  )
  u_sram
  (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_size_i  (ar_size),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .aw_valid_i (aw_valid),
    .aw_addr_i  (aw_addr),
    .aw_size_i  (aw_size),
    .aw_ready_o (aw_ready),
    .w_valid_i  (w_valid),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .w_ready_o  (w_ready),
    .b_valid_o  (b_valid)
  );

endmodule

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter
(
  input  logic                       clk,
  input  logic                       rst,
  // fetch port
  input  logic                       ifu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  output logic                       ifu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  // load port
  input  logic                       lsu_arvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  bus_pkg::size_t             lsu_rsize_i,
  output logic                       lsu_rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  // store port
  input  logic                       lsu_awvalid_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0] lsu_wdata_i,
  input  bus_pkg::size_t             lsu_wsize_i,
  output logic                       lsu_wready_o,
  // memory channels
  output logic                       ar_valid_o,
  output logic [bus_pkg::ADDR_W-1:0] ar_addr_o,
  output bus_pkg::size_t             ar_size_o,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  logic [bus_pkg::BUS_W-1:0]  r_data_i,
  output logic                       aw_valid_o,
  output logic [bus_pkg::ADDR_W-1:0] aw_addr_o,
  output bus_pkg::size_t             aw_size_o,
  input  logic                       aw_ready_i,
  output logic                       w_valid_o,
  output logic [bus_pkg::BUS_W-1:0]  w_data_o,
  output logic [bus_pkg::STRB_W-1:0] w_strb_o,
  input  logic                       w_ready_i,
  input  logic                       b_valid_i,
  // timer
  output logic                       tmr_rd_o,
  output logic                       tmr_hi_o,
  input  logic                       tmr_rvalid_i,
  input  logic [bus_pkg::DATA_W-1:0] tmr_rdata_i
);

  typedef enum logic [3:0]
  {
    ST_IDLE, ST_IF_ADDR, ST_IF_DATA, ST_LD_ADDR, ST_LD_DATA,
    ST_TMR_WAIT, ST_ST_ADDR, ST_ST_DATA, ST_ST_RESP
  } state_t;

  state_t                     state;
  logic [bus_pkg::ADDR_W-1:0] addr_q;
  bus_pkg::size_t             size_q;
  logic                       ar_valid_q;
  logic                       aw_valid_q;
  logic                       w_valid_q;
  logic                       tmr_rd_q;
  logic                       lsu_tmr_hit;
  logic [bus_pkg::DATA_W-1:0] lane_rdata;
  logic [bus_pkg::DATA_W-1:0] wdata_shift;
  logic [3:0]                 strb_base;
  logic [3:0]                 strb_lane;

  assign lsu_tmr_hit = (lsu_araddr_i == bus_pkg::MTIME_ADDR) ||
                       (lsu_araddr_i == bus_pkg::MTIME_ADDR_HI);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= ST_IDLE;
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      tmr_rd_q   <= 1'b0;
    end
    else
    begin
      tmr_rd_q <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          // store beats load, lsu beats fetch
          if (lsu_awvalid_i)
          begin
            state      <= ST_ST_ADDR;
            aw_valid_q <= 1'b1;
          end
          else if (lsu_arvalid_i && lsu_tmr_hit)
          begin
            state    <= ST_TMR_WAIT;
            tmr_rd_q <= 1'b1;
          end
          else if (lsu_arvalid_i)
          begin
            state      <= ST_LD_ADDR;
            ar_valid_q <= 1'b1;
          end
          else if (ifu_arvalid_i)
          begin
            state      <= ST_IF_ADDR;
            ar_valid_q <= 1'b1;
          end
        end
        ST_IF_ADDR, ST_LD_ADDR:
        begin
          if (ar_ready_i)
          begin
            state      <= (state == ST_IF_ADDR) ? ST_IF_DATA : ST_LD_DATA;
            ar_valid_q <= 1'b0;
          end
        end
        ST_IF_DATA, ST_LD_DATA:
        begin
          if (r_valid_i)
          begin
            state <= ST_IDLE;
          end
        end
        ST_TMR_WAIT:
        begin
          if (tmr_rvalid_i)
          begin
            state <= ST_IDLE;
          end
        end
        ST_ST_ADDR:
        begin
          if (aw_ready_i)
          begin
            state      <= ST_ST_DATA;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b1;
          end
        end
        ST_ST_DATA:
        begin
          if (w_ready_i)
          begin
            state     <= ST_ST_RESP;
            w_valid_q <= 1'b0;
          end
        end
        ST_ST_RESP:
        begin
          if (b_valid_i)
          begin
            state <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // winner's address and size, fetches are always full words
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE)
    begin
      if (lsu_awvalid_i)
      begin
        addr_q <= lsu_awaddr_i;
        size_q <= lsu_wsize_i;
      end
      else if (lsu_arvalid_i)
      begin
        addr_q <= lsu_araddr_i;
        size_q <= lsu_rsize_i;
      end
      else
      begin
        addr_q <= ifu_araddr_i;
        size_q <= bus_pkg::SIZE_WORD;
      end
    end
  end

  // read lane from address bit 2
  assign lane_rdata   = addr_q[2] ? r_data_i[63:32] : r_data_i[31:0];
  assign ifu_rdata_o  = lane_rdata;
  assign ifu_rvalid_o = (state == ST_IF_DATA) && r_valid_i;
  assign lsu_rdata_o  = (state == ST_TMR_WAIT) ? tmr_rdata_i : lane_rdata;
  assign lsu_rvalid_o = ((state == ST_LD_DATA) && r_valid_i) ||
                        ((state == ST_TMR_WAIT) && tmr_rvalid_i);
  assign lsu_wready_o = (state == ST_ST_RESP) && b_valid_i;

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = addr_q;
  assign ar_size_o  = size_q;
  assign aw_valid_o = aw_valid_q;
  assign aw_addr_o  = addr_q;
  assign aw_size_o  = size_q;
  assign w_valid_o  = w_valid_q;

  // byte offset shift, same word on both lanes
  assign wdata_shift = lsu_wdata_i << {addr_q[1:0], 3'b000};
  assign w_data_o    = {wdata_shift, wdata_shift};

  always_comb
  begin
    case (size_q)
      bus_pkg::SIZE_BYTE: strb_base = 4'b0001;
      bus_pkg::SIZE_HALF: strb_base = 4'b0011;
      default:            strb_base = 4'b1111;
    endcase
  end

  assign strb_lane = strb_base << addr_q[1:0];
  assign w_strb_o  = addr_q[2] ? {strb_lane, 4'b0000} : {4'b0000, strb_lane};

  assign tmr_rd_o = tmr_rd_q;
  assign tmr_hi_o = (addr_q == bus_pkg::MTIME_ADDR_HI);

endmodule

// ==== verilog/sram_slave.sv ====
`timescale 1ns/1ps

module sram_slave
#(
  parameter int SRAM_WORDS   = 1024,
  parameter int RESP_LATENCY = 3
)
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ar_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] ar_addr_i,
  input  bus_pkg::size_t             ar_size_i,
  output logic                       ar_ready_o,
  output logic                       r_valid_o,
  output logic [bus_pkg::BUS_W-1:0]  r_data_o,
  input  logic                       aw_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] aw_addr_i,
  input  bus_pkg::size_t             aw_size_i,
  output logic                       aw_ready_o,
  input  logic                       w_valid_i,
  input  logic [bus_pkg::BUS_W-1:0]  w_data_i,
  input  logic [bus_pkg::STRB_W-1:0] w_strb_i,
  output logic                       w_ready_o,
  output logic                       b_valid_o
);

  localparam int IDX_W = $clog2(SRAM_WORDS);
  localparam int CNT_W = $clog2(RESP_LATENCY + 1);

  typedef enum logic [1:0] {SR_IDLE, SR_WDATA, SR_RBUSY, SR_WBUSY} sram_state_t;

  sram_state_t              state;
  logic [CNT_W-1:0]         cnt;
  logic [IDX_W-1:0]         idx_q;
  logic [bus_pkg::BUS_W-1:0] mem [0:SRAM_WORDS-1];

  // a write address wins if both show up together
  assign aw_ready_o = (state == SR_IDLE);
  assign ar_ready_o = (state == SR_IDLE) && !aw_valid_i;
  assign w_ready_o  = (state == SR_WDATA);

  // response fires on the last count
  assign r_valid_o = (state == SR_RBUSY) && (cnt == CNT_W'(1));
  assign b_valid_o = (state == SR_WBUSY) && (cnt == CNT_W'(1));
  assign r_data_o  = mem[idx_q];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= SR_IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        SR_IDLE:
        begin
          if (aw_valid_i)
          begin
            state <= SR_WDATA;
          end
          else if (ar_valid_i)
          begin
            state <= SR_RBUSY;
            cnt   <= CNT_W'(RESP_LATENCY);
          end
        end
        SR_WDATA:
        begin
          if (w_valid_i)
          begin
            state <= SR_WBUSY;
            cnt   <= CNT_W'(RESP_LATENCY);
          end
        end
        default:
        begin
          if (cnt == CNT_W'(1))
          begin
            state <= SR_IDLE;
          end
          cnt <= cnt - CNT_W'(1);
        end
      endcase
    end
  end

  // 64-bit word index sits above the byte-in-word bits
  always_ff @(posedge clk)
  begin
    if (state == SR_IDLE)
    begin
      idx_q <= aw_valid_i ? aw_addr_i[IDX_W+2:3] : ar_addr_i[IDX_W+2:3];
    end
    if (w_valid_i && w_ready_o)
    begin
      for (int b = 0; b < bus_pkg::STRB_W; b++)
      begin
        if (w_strb_i[b])
        begin
          mem[idx_q][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== verilog/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_i,
  input  logic                       hi_i,
  output logic                       rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] rdata_o
);

  logic [63:0] mtime;

  // free running, cleared only by reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= 64'd0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= rd_i;
    end
  end

  // selected half, valid the cycle after rd_i
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      rdata_o <= hi_i ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // master side widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // memory bus widths
  localparam int BUS_W  = 64;
  localparam int STRB_W = BUS_W / 8;

  // machine timer words, low then high
  localparam logic [ADDR_W-1:0] MTIME_ADDR    = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] MTIME_ADDR_HI = 32'h0200_bffc;

  // access size, doubles as the axi size field encoding
  typedef enum logic [2:0]
  {
    SIZE_BYTE = 3'd0,
    SIZE_HALF = 3'd1,
    SIZE_WORD = 3'd2
  } size_t;

endpackage
